//--- rename_core.f
+incdir+include
hw/rename_pkg.sv
hw/rat_bank.sv
hw/rename_table.sv
hw/intra_group_bypass.sv
hw/rename_core.sv
test/rename_core_asserts.sv
test/rename_core_tb.sv

//--- test/rename_core_tb.sv
`timescale 1ns/100ps
`include "rename_consts.svh"

module rename_core_tb
    import rename_pkg::*;
();

    localparam int CLK_HALF        = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int IDLE_CYCLES     = 16;
    localparam int RENAME_CYCLES   = 200;
    localparam int SAME_DST_CYCLES = 50;
    localparam int COMMIT_CYCLES   = 200;
    localparam int WALK_CYCLES     = 200;
    localparam int MIXED_CYCLES    = 2000;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + IDLE_CYCLES + RENAME_CYCLES +
                                     SAME_DST_CYCLES + COMMIT_CYCLES + WALK_CYCLES +
                                     MIXED_CYCLES;
    localparam int TIMEOUT_NS      = TOTAL_CYCLES * 2 * CLK_HALF + 4000;

    localparam int MODE_IDLE     = 0;
    localparam int MODE_RENAME   = 1;
    localparam int MODE_SAME_DST = 2;
    localparam int MODE_COMMIT   = 3;
    localparam int MODE_WALK     = 4;
    localparam int MODE_MIXED    = 5;

    logic                                   clk;
    logic                                   rst;
    rename_slot_t   [`FETCH_WIDTH-1:0]      rename_group;
    commit_slot_t   [`COMMIT_WIDTH-1:0]     commit_group;
    logic                                   walk;
    commit_slot_t   [`COMMIT_WIDTH-1:0]     walk_group;
    rename_result_t [`FETCH_WIDTH-1:0]      rename_result;
    free_slot_t     [`COMMIT_WIDTH-1:0]     free_list_ret;

    // Reference tables, indexed by class then register.
    preg_t spec_map [2][`VREG_NUM];
    preg_t comm_map [2][`VREG_NUM];
    int    walk_left;

    rename_core rename_core_i (
        .clk           (clk),
        .rst           (rst),
        .rename_group  (rename_group),
        .commit_group  (commit_group),
        .walk          (walk),
        .walk_group    (walk_group),
        .rename_result (rename_result),
        .free_list_ret (free_list_ret)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what, actual,
                     expected);
            $display("RESULT: FAIL");
            $fatal(1, "Output mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~

    // Applies the group that was presented before this edge.
    task automatic update_model();
        if (walk) begin
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (walk_group[i].en && walk_group[i].we) begin
                    spec_map[walk_group[i].fp][walk_group[i].vrd] = walk_group[i].old_prd;
                end
            end
        end else begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (rename_group[i].valid && rename_group[i].we) begin
                    spec_map[rename_group[i].fp][rename_group[i].vrd] = rename_group[i].prd;
                end
            end
        end
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            if (commit_group[c].en && commit_group[c].we) begin
                comm_map[commit_group[c].fp][commit_group[c].vrd] = commit_group[c].prd;
            end
        end
    endtask

    task automatic check_outputs();
        preg_t view [2][`VREG_NUM];
        logic  later_hit;
        view = spec_map;
        // Each slot sees the table as left by the older slots of its group.
        if (!walk) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                for (int s = 0; s < `SRC_NUM; s++) begin
                    check_value(rename_result[i].psrc[s],
                                view[rename_group[i].src_fp[s]][rename_group[i].vsrc[s]],
                                $sformatf("rename slot %0d source %0d tag", i, s));
                end
                check_value(rename_result[i].old_prd,
                            view[rename_group[i].fp][rename_group[i].vrd],
                            $sformatf("rename slot %0d previous mapping", i));
                if (rename_group[i].valid && rename_group[i].we) begin
                    view[rename_group[i].fp][rename_group[i].vrd] = rename_group[i].prd;
                end
            end
        end
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            later_hit = 1'b0;
            check_value(free_list_ret[c].valid, commit_group[c].en && commit_group[c].we,
                        $sformatf("commit slot %0d free valid", c));
            if (commit_group[c].en && commit_group[c].we) begin
                for (int k = c + 1; k < `COMMIT_WIDTH; k++) begin
                    if (commit_group[k].en && commit_group[k].we &&
                        (commit_group[k].fp == commit_group[c].fp) &&
                        (commit_group[k].vrd == commit_group[c].vrd)) begin
                        later_hit = 1'b1;
                    end
                end
                check_value(free_list_ret[c].prd,
                            later_hit ? commit_group[c].prd :
                                        comm_map[commit_group[c].fp][commit_group[c].vrd],
                            $sformatf("commit slot %0d freed tag", c));
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_outputs();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic rename_slot_t rand_rename_slot(input int span);
        rename_slot_t slot;
        slot.valid = ($urandom % 4) != 0;
        slot.we    = ($urandom % 3) != 0;
        slot.fp    = 1'($urandom % 2);
        for (int s = 0; s < `SRC_NUM; s++) begin
            slot.vsrc[s]   = vreg_t'($urandom % span);
            slot.src_fp[s] = 1'($urandom % 2);
        end
        slot.vrd = vreg_t'($urandom % span);
        slot.prd = preg_t'($urandom);
        return slot;
    endfunction

    function automatic commit_slot_t rand_commit_slot(input int span);
        commit_slot_t slot;
        slot.en      = ($urandom % 4) != 0;
        slot.we      = ($urandom % 4) != 0;
        slot.fp      = 1'($urandom % 2);
        slot.vrd     = vreg_t'($urandom % span);
        slot.prd     = preg_t'($urandom);
        slot.old_prd = preg_t'($urandom);
        return slot;
    endfunction

    task automatic step(input int mode, input int n);
        rename_slot_t [`FETCH_WIDTH-1:0]  next_rename;
        commit_slot_t [`COMMIT_WIDTH-1:0] next_commit;
        commit_slot_t [`COMMIT_WIDTH-1:0] next_walk;
        logic                             next_walk_on;
        vreg_t                            shared_rd;
        logic                             shared_fp;

        @(posedge clk);
        update_model();

        next_commit  = '0;
        next_walk    = '0;
        next_walk_on = 1'b0;
        shared_rd    = vreg_t'($urandom % 4);
        shared_fp    = 1'($urandom % 2);
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            next_rename[i] = rand_rename_slot(8);
            case (mode)
                MODE_IDLE: begin
                    // Sweep every register of one class per four cycles.
                    next_rename[i].valid = 1'b0;
                    for (int s = 0; s < `SRC_NUM; s++) begin
                        next_rename[i].vsrc[s]   =
                            vreg_t'(n * `FETCH_WIDTH * `SRC_NUM + i * `SRC_NUM + s);
                        next_rename[i].src_fp[s] = 1'((n / 4) % 2);
                    end
                    next_rename[i].vrd = next_rename[i].vsrc[0];
                    next_rename[i].fp  = next_rename[i].src_fp[0];
                end
                MODE_SAME_DST: begin
                    next_rename[i].valid = 1'b1;
                    next_rename[i].we    = 1'b1;
                    next_rename[i].vrd   = shared_rd;
                    next_rename[i].fp    = shared_fp;
                end
                default: begin
                end
            endcase
        end
        if (mode == MODE_COMMIT || mode == MODE_MIXED) begin
            for (int c = 0; c < `COMMIT_WIDTH; c++) begin
                next_commit[c] = rand_commit_slot(mode == MODE_COMMIT ? 4 : 6);
            end
        end
        if (mode == MODE_WALK || mode == MODE_MIXED) begin
            if (walk_left == 0 && ($urandom % 6) == 0) begin
                walk_left = 3 + int'($urandom % 4);
            end
            if (walk_left > 0) begin
                next_walk_on = 1'b1;
                walk_left--;
                for (int c = 0; c < `COMMIT_WIDTH; c++) begin
                    next_walk[c] = rand_commit_slot(6);
                end
            end
        end

        rename_group <= next_rename;
        commit_group <= next_commit;
        walk         <= next_walk_on;
        walk_group   <= next_walk;
    endtask

    task automatic run_phase(input int mode, input int cycles);
        for (int n = 0; n < cycles; n++) begin
            step(mode, n);
        end
    endtask

    initial begin
        void'($urandom(32'h8cc8_d2fb));
        clk          = 1'b0;
        rst          = 1'b1;
        rename_group = '0;
        commit_group = '0;
        walk         = 1'b0;
        walk_group   = '0;
        walk_left    = 0;
        for (int cls = 0; cls < 2; cls++) begin
            for (int r = 0; r < `VREG_NUM; r++) begin
                spec_map[cls][r] = preg_t'(r);
                comm_map[cls][r] = preg_t'(r);
            end
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        run_phase(MODE_IDLE, IDLE_CYCLES);
        run_phase(MODE_RENAME, RENAME_CYCLES);
        run_phase(MODE_SAME_DST, SAME_DST_CYCLES);
        run_phase(MODE_COMMIT, COMMIT_CYCLES);
        run_phase(MODE_WALK, WALK_CYCLES);
        run_phase(MODE_MIXED, MIXED_CYCLES);

        // Let the last group be checked on its falling edge.
        @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

    // Hang guard.
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $fatal(1, "Timeout");
    end

endmodule

//--- test/rename_core_asserts.sv
`timescale 1ns/100ps
`include "rename_consts.svh"

module rename_core_asserts
    import rename_pkg::*;
(
    input logic                                 clk,
    input logic                                 rst,
    input commit_slot_t   [`COMMIT_WIDTH-1:0]   commit_group,
    input rename_result_t [`FETCH_WIDTH-1:0]    rename_result,
    input free_slot_t     [`COMMIT_WIDTH-1:0]   free_list_ret
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Free tag port
    // ~~~~~~~~~~~~~~~~~~~~

    genvar c;
    generate
        for (c = 0; c < `COMMIT_WIDTH; c++) begin : g_free
            free_needs_commit: assert property (@(posedge clk) disable iff (rst)
                free_list_ret[c].valid |-> (commit_group[c].en && commit_group[c].we))
                else $error("Free valid on slot %0d without a committing write", c);

            free_low_in_reset: assert property (@(posedge clk)
                rst |-> !free_list_ret[c].valid)
                else $error("Free valid on slot %0d while reset is active", c);
        end
    endgenerate

    // Nothing unknown once out of reset.
    outputs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(rename_result) && !$isunknown(free_list_ret))
        else $error("Unknown value on a rename or free output");

endmodule

bind rename_core rename_core_asserts asserts_i (
    .clk           (clk),
    .rst           (rst),
    .commit_group  (commit_group),
    .rename_result (rename_result),
    .free_list_ret (free_list_ret)
);

//--- hw/rename_core.sv
`timescale 1ns/100ps
`include "rename_consts.svh"

module rename_core
    import rename_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  rename_slot_t   [`FETCH_WIDTH-1:0]   rename_group,
    input  commit_slot_t   [`COMMIT_WIDTH-1:0]  commit_group,
    input  logic                                walk,
    input  commit_slot_t   [`COMMIT_WIDTH-1:0]  walk_group,
    output rename_result_t [`FETCH_WIDTH-1:0]   rename_result,
    output free_slot_t     [`COMMIT_WIDTH-1:0]  free_list_ret
);

    preg_t [`FETCH_WIDTH-1:0][`SRC_NUM-1:0] int_psrc;
    preg_t [`FETCH_WIDTH-1:0][`SRC_NUM-1:0] fp_psrc;
    preg_t [`FETCH_WIDTH-1:0][`SRC_NUM-1:0] sel_psrc;
    preg_t [`FETCH_WIDTH-1:0]               int_old_prd;
    preg_t [`FETCH_WIDTH-1:0]               fp_old_prd;
    preg_t [`FETCH_WIDTH-1:0]               sel_old_prd;
    preg_t [`COMMIT_WIDTH-1:0]              int_free;
    preg_t [`COMMIT_WIDTH-1:0]              fp_free;

    rename_table #(.FPV(0)) int_table (
        .clk            (clk),
        .rst            (rst),
        .rename_group   (rename_group),
        .commit_group   (commit_group),
        .walk           (walk),
        .walk_group     (walk_group),
        .lookup_psrc    (int_psrc),
        .lookup_old_prd (int_old_prd),
        .free_prd       (int_free)
    );

    rename_table #(.FPV(1)) fp_table (
        .clk            (clk),
        .rst            (rst),
        .rename_group   (rename_group),
        .commit_group   (commit_group),
        .walk           (walk),
        .walk_group     (walk_group),
        .lookup_psrc    (fp_psrc),
        .lookup_old_prd (fp_old_prd),
        .free_prd       (fp_free)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Class selects
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            for (int s = 0; s < `SRC_NUM; s++) begin
                sel_psrc[i][s] = rename_group[i].src_fp[s] ? fp_psrc[i][s] : int_psrc[i][s];
            end
            sel_old_prd[i] = rename_group[i].fp ? fp_old_prd[i] : int_old_prd[i];
        end
    end

    // Exactly one table owns each commit slot.
    always_comb begin
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            free_list_ret[c].valid = commit_group[c].en && commit_group[c].we;
            free_list_ret[c].prd   = commit_group[c].fp ? fp_free[c] : int_free[c];
        end
    end

    intra_group_bypass bypass (
        .rename_group   (rename_group),
        .lookup_psrc    (sel_psrc),
        .lookup_old_prd (sel_old_prd),
        .rename_result  (rename_result)
    );

endmodule

//--- hw/intra_group_bypass.sv
`timescale 1ns/100ps
`include "rename_consts.svh"

module intra_group_bypass
    import rename_pkg::*;
(
    input  rename_slot_t   [`FETCH_WIDTH-1:0]               rename_group,
    input  preg_t          [`FETCH_WIDTH-1:0][`SRC_NUM-1:0] lookup_psrc,
    input  preg_t          [`FETCH_WIDTH-1:0]               lookup_old_prd,
    output rename_result_t [`FETCH_WIDTH-1:0]               rename_result
);

    logic [`FETCH_WIDTH-1:0] writes_dst;

    always_comb begin
        for (int j = 0; j < `FETCH_WIDTH; j++) begin
            writes_dst[j] = rename_group[j].valid && rename_group[j].we;
        end
    end

    // Older slots are scanned first, so the nearest writer is applied last.
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            rename_result[i].psrc    = lookup_psrc[i];
            rename_result[i].old_prd = lookup_old_prd[i];

            for (int j = 0; j < i; j++) begin
                for (int s = 0; s < `SRC_NUM; s++) begin
                    // Class must match too.
                    if (writes_dst[j] &&
                        (rename_group[j].fp == rename_group[i].src_fp[s]) &&
                        (rename_group[j].vrd == rename_group[i].vsrc[s])) begin
                        rename_result[i].psrc[s] = rename_group[j].prd;
                    end
                end

                if (writes_dst[j] &&
                    (rename_group[j].fp == rename_group[i].fp) &&
                    (rename_group[j].vrd == rename_group[i].vrd)) begin
                    rename_result[i].old_prd = rename_group[j].prd;
                end
            end
        end
    end

endmodule

//--- hw/rename_table.sv
`timescale 1ns/100ps
`include "rename_consts.svh"

module rename_table
    import rename_pkg::*;
#(
    parameter int FPV = 0
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  rename_slot_t [`FETCH_WIDTH-1:0]             rename_group,
    input  commit_slot_t [`COMMIT_WIDTH-1:0]            commit_group,
    input  logic                                        walk,
    input  commit_slot_t [`COMMIT_WIDTH-1:0]            walk_group,
    output preg_t        [`FETCH_WIDTH-1:0][`SRC_NUM-1:0] lookup_psrc,
    output preg_t        [`FETCH_WIDTH-1:0]             lookup_old_prd,
    output preg_t        [`COMMIT_WIDTH-1:0]            free_prd
);

    localparam logic CLASS_BIT = (FPV != 0);
    localparam int   SPEC_WR_NUM = (`FETCH_WIDTH > `COMMIT_WIDTH) ?
                                   `FETCH_WIDTH : `COMMIT_WIDTH;

    rat_wr_t [SPEC_WR_NUM-1:0]      spec_wr;
    rat_wr_t [`COMMIT_WIDTH-1:0]    commit_wr;
    logic    [`COMMIT_WIDTH-1:0]    commit_we;
    logic    [`COMMIT_WIDTH-1:0]    commit_cancel;
    vreg_t   [`FETCH_WIDTH-1:0]     rd_raddr;
    vreg_t   [`COMMIT_WIDTH-1:0]    commit_raddr;
    preg_t   [`COMMIT_WIDTH-1:0]    commit_rdata;

    // ~~~~~~~~~~~~~~~~~~~~
    // Speculative writes
    // ~~~~~~~~~~~~~~~~~~~~

    // Walk restores old mappings and blocks renaming.
    always_comb begin
        spec_wr = '0;
        if (walk) begin
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                spec_wr[i].we    = walk_group[i].en && walk_group[i].we &&
                                   (walk_group[i].fp == CLASS_BIT);
                spec_wr[i].waddr = walk_group[i].vrd;
                spec_wr[i].wdata = walk_group[i].old_prd;
            end
        end else begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                spec_wr[i].we    = rename_group[i].valid && rename_group[i].we &&
                                   (rename_group[i].fp == CLASS_BIT);
                spec_wr[i].waddr = rename_group[i].vrd;
                spec_wr[i].wdata = rename_group[i].prd;
            end
        end
    end

    // One bank per source so every slot gets its own read ports.
    genvar s, i;
    generate
        for (s = 0; s < `SRC_NUM; s++) begin : g_src
            vreg_t [`FETCH_WIDTH-1:0] src_raddr;
            preg_t [`FETCH_WIDTH-1:0] src_rdata;

            for (i = 0; i < `FETCH_WIDTH; i++) begin : g_slot
                assign src_raddr[i]      = rename_group[i].vsrc[s];
                assign lookup_psrc[i][s] = src_rdata[i];
            end

            rat_bank #(
                .RD_NUM (`FETCH_WIDTH),
                .WR_NUM (SPEC_WR_NUM)
            ) src_bank (
                .clk   (clk),
                .rst   (rst),
                .raddr (src_raddr),
                .rdata (src_rdata),
                .wr    (spec_wr)
            );
        end

        for (i = 0; i < `FETCH_WIDTH; i++) begin : g_rd_addr
            assign rd_raddr[i] = rename_group[i].vrd;
        end
    endgenerate

    rat_bank #(
        .RD_NUM (`FETCH_WIDTH),
        .WR_NUM (SPEC_WR_NUM)
    ) rd_bank (
        .clk   (clk),
        .rst   (rst),
        .raddr (rd_raddr),
        .rdata (lookup_old_prd),
        .wr    (spec_wr)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Committed table
    // ~~~~~~~~~~~~~~~~~~~~

    // A younger commit to the same register overrides this one.
    always_comb begin
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            commit_we[c] = commit_group[c].en && commit_group[c].we &&
                           (commit_group[c].fp == CLASS_BIT);
        end
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            commit_cancel[c] = 1'b0;
            for (int k = c + 1; k < `COMMIT_WIDTH; k++) begin
                if (commit_we[c] && commit_we[k] &&
                    (commit_group[c].vrd == commit_group[k].vrd)) begin
                    commit_cancel[c] = 1'b1;
                end
            end
        end
    end

    generate
        for (i = 0; i < `COMMIT_WIDTH; i++) begin : g_commit
            assign commit_raddr[i]    = commit_group[i].vrd;
            assign commit_wr[i].we    = commit_we[i] && !commit_cancel[i];
            assign commit_wr[i].waddr = commit_group[i].vrd;
            assign commit_wr[i].wdata = commit_group[i].prd;
            // Cancelled slot never reached the table, so its own tag goes back.
            assign free_prd[i] = commit_cancel[i] ? commit_group[i].prd : commit_rdata[i];
        end
    endgenerate

    rat_bank #(
        .RD_NUM (`COMMIT_WIDTH),
        .WR_NUM (`COMMIT_WIDTH)
    ) commit_bank (
        .clk   (clk),
        .rst   (rst),
        .raddr (commit_raddr),
        .rdata (commit_rdata),
        .wr    (commit_wr)
    );

endmodule

//--- hw/rat_bank.sv
`timescale 1ns/100ps
`include "rename_consts.svh"

module rat_bank
    import rename_pkg::*;
#(
    parameter int RD_NUM = `FETCH_WIDTH,
    parameter int WR_NUM = `FETCH_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  vreg_t   [RD_NUM-1:0]    raddr,
    output preg_t   [RD_NUM-1:0]    rdata,
    input  rat_wr_t [WR_NUM-1:0]    wr
);

    // One tag per architectural register.
    preg_t map [`VREG_NUM];

    // Read ports see the table before this edge's writes.
    genvar r;
    generate
        for (r = 0; r < RD_NUM; r++) begin : g_rd
            assign rdata[r] = map[raddr[r]];
        end
    endgenerate

    // Identity mapping after reset.
    // Later ports overwrite earlier ones on the same entry.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `VREG_NUM; i++) begin
                map[i] <= preg_t'(i);
            end
        end else begin
            for (int w = 0; w < WR_NUM; w++) begin
                if (wr[w].we) begin
                    map[wr[w].waddr] <= wr[w].wdata;
                end
            end
        end
    end

endmodule

//--- hw/rename_pkg.sv
`include "rename_consts.svh"

package rename_pkg;

    typedef logic [`VREG_WIDTH-1:0] vreg_t;
    typedef logic [`PREG_WIDTH-1:0] preg_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Rename side
    // ~~~~~~~~~~~~~~~~~~~~

    // One instruction entering rename.
    typedef struct packed {
        logic                       valid;
        logic                       we;
        logic                       fp;
        vreg_t [`SRC_NUM-1:0]       vsrc;
        logic  [`SRC_NUM-1:0]       src_fp;
        vreg_t                      vrd;
        preg_t                      prd;
    } rename_slot_t;

    typedef struct packed {
        preg_t [`SRC_NUM-1:0]       psrc;
        preg_t                      old_prd;
    } rename_result_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Commit and walk side
    // ~~~~~~~~~~~~~~~~~~~~

    // Shared by commit groups and walk groups.
    typedef struct packed {
        logic                       en;
        logic                       we;
        logic                       fp;
        vreg_t                      vrd;
        preg_t                      prd;
        preg_t                      old_prd;
    } commit_slot_t;

    typedef struct packed {
        logic                       valid;
        preg_t                      prd;
    } free_slot_t;

    // One write port of a map bank.
    typedef struct packed {
        logic                       we;
        vreg_t                      waddr;
        preg_t                      wdata;
    } rat_wr_t;

endpackage

//--- include/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Group sizes.
`define FETCH_WIDTH   4
`define COMMIT_WIDTH  4

// Sources per instruction.
`define SRC_NUM       2

// Architectural register file of one class.
`define VREG_NUM      32
`define VREG_WIDTH    5

// Physical tag.
`define PREG_WIDTH    7

`endif
